//--- hdl/rv_defs.svh
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`define XLEN        32
`define REG_IDX_W   5
`define EXC_W       4

// trap causes as in mcause
`define EXC_IAM     4'd0
`define EXC_II      4'd2
`define EXC_BP      4'd3
`define EXC_EC      4'd11
`define EXC_NONE    4'd15

// register byte offsets
`define AXI_ADDR_W      5
`define ADDR_INST       5'h00
`define ADDR_RS1        5'h04
`define ADDR_RS2        5'h08
`define ADDR_PC         5'h0C
`define ADDR_RD_VALUE   5'h10
`define ADDR_NEXT_PC    5'h14
`define ADDR_STATUS     5'h18

`endif

//--- hdl/rv_pkg.sv
`include "rv_defs.svh"

package rv_pkg;

    // major opcode, inst[6:2]
    typedef enum logic [4:0] {
        opc_op_imm = 5'b00100,
        opc_auipc  = 5'b00101,
        opc_op_reg = 5'b01100,
        opc_lui    = 5'b01101,
        opc_branch = 5'b11000,
        opc_jalr   = 5'b11001,
        opc_jal    = 5'b11011,
        opc_system = 5'b11100
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b,  // lui
        alu_add_pc   // auipc
    } alu_op_e;

    typedef enum logic [3:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu,
        br_jal,
        br_jalr
    } branch_op_e;

    typedef struct packed {
        logic                   valid;
        alu_op_e                alu_op;
        branch_op_e             branch_op;
        logic                   use_imm;
        logic [`XLEN-1:0]       imm;
        logic [`REG_IDX_W-1:0]  rd;
        logic                   we;
        logic [`EXC_W-1:0]      exccode;
        logic [`XLEN-1:0]       rs1_val;  // operands ride along with the instruction
        logic [`XLEN-1:0]       rs2_val;
        logic [`XLEN-1:0]       pc;
    } decode_info_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       rd_value;
        logic [`XLEN-1:0]       next_pc;
        logic [`REG_IDX_W-1:0]  rd;
        logic                   we;
        logic                   taken;
        logic [`EXC_W-1:0]      exccode;
    } exec_result_t;

endpackage

//--- hdl/rv_axil_regs.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_axil_regs import rv_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`AXI_ADDR_W-1:0]  s_awaddr,
    input  logic                    s_awvalid,
    output logic                    s_awready,
    input  logic [`XLEN-1:0]        s_wdata,
    input  logic [`XLEN/8-1:0]      s_wstrb,
    input  logic                    s_wvalid,
    output logic                    s_wready,
    output logic [1:0]              s_bresp,
    output logic                    s_bvalid,
    input  logic                    s_bready,
    input  logic [`AXI_ADDR_W-1:0]  s_araddr,
    input  logic                    s_arvalid,
    output logic                    s_arready,
    output logic [`XLEN-1:0]        s_rdata,
    output logic [1:0]              s_rresp,
    output logic                    s_rvalid,
    input  logic                    s_rready,
    output decode_info_t            launch,
    output logic [`XLEN-1:0]        inst,
    input  exec_result_t            result,
    input  logic [7:0]              done_count
);

    logic                wr_ready;
    logic                wr_fire;
    logic                ar_fire;
    logic                inst_go;
    logic                launch_go;
    logic [`XLEN-1:0]    strb_mask;
    logic [`XLEN-1:0]    rs1_q, rs2_q, pc_q;
    logic [`XLEN-1:0]    status;
    logic [`XLEN-1:0]    rd_mux;

    function automatic logic [`XLEN-1:0] merge(input logic [`XLEN-1:0] old);
        return (old & ~strb_mask) | (s_wdata & strb_mask);
    endfunction

    always_comb begin
        for (int i = 0; i < `XLEN/8; i++)
            strb_mask[8*i +: 8] = {8{s_wstrb[i]}};
    end

    assign s_awready = wr_ready;
    assign s_wready  = wr_ready;
    assign s_bresp   = 2'b00;
    assign s_rresp   = 2'b00;
    assign wr_fire   = wr_ready && s_awvalid && s_wvalid;
    assign ar_fire   = s_arvalid && s_arready;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ready  <= 1'b0;
            s_bvalid  <= 1'b0;
            inst_go   <= 1'b0;
            launch_go <= 1'b0;
            rs1_q     <= '0;
            rs2_q     <= '0;
            pc_q      <= '0;
            inst      <= '0;
        end else begin
            // one-cycle ready, held off while a response is pending
            wr_ready  <= s_awvalid && s_wvalid && !wr_ready && !s_bvalid;
            inst_go   <= wr_fire && s_awaddr == `ADDR_INST;
            launch_go <= inst_go;
            if (wr_fire)
                s_bvalid <= 1'b1;
            else if (s_bready)
                s_bvalid <= 1'b0;
            if (wr_fire) begin
                case (s_awaddr)
                    `ADDR_INST: inst  <= merge(inst);
                    `ADDR_RS1:  rs1_q <= merge(rs1_q);
                    `ADDR_RS2:  rs2_q <= merge(rs2_q);
                    `ADDR_PC:   pc_q  <= merge(pc_q);
                    default:    ;  // read-only or unmapped
                endcase
            end
        end
    end

    always_comb begin
        launch         = '0;
        launch.valid   = launch_go;
        launch.rs1_val = rs1_q;
        launch.rs2_val = rs2_q;
        launch.pc      = pc_q;
    end

    assign status = {8'd0, done_count, 3'd0, result.rd, 2'd0,
                     result.taken, result.we, result.exccode};

    always_comb begin
        case (s_araddr)
            `ADDR_RD_VALUE: rd_mux = result.rd_value;
            `ADDR_NEXT_PC:  rd_mux = result.next_pc;
            `ADDR_STATUS:   rd_mux = status;
            default:        rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s_arready <= 1'b0;
            s_rvalid  <= 1'b0;
        end else begin
            if (ar_fire)
                s_rvalid <= 1'b1;
            else if (s_rready)
                s_rvalid <= 1'b0;
            s_arready <= !ar_fire && !(s_rvalid && !s_rready);
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire)
            s_rdata <= rd_mux;
    end

    a_bvalid_hold: assert property (@(posedge clk) disable iff (reset)
        s_bvalid && !s_bready |=> s_bvalid);

endmodule

//--- hdl/rv_decode.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_decode import rv_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic [`XLEN-1:0]  inst,
    input  decode_info_t      launch,
    output decode_info_t      dec
);

    opcode_e                op;
    logic [2:0]             funct3;
    logic [6:0]             funct7;
    logic                   low_ok;
    logic                   f7_zero;
    logic                   f7_alt;
    logic                   f7_ok;
    logic                   is_lui, is_auipc, is_jal, is_jalr;
    logic                   is_branch, is_op_imm, is_op_reg;
    logic                   sys_zero, is_ecall, is_ebreak, legal;
    logic [`XLEN-1:0]       i_imm, b_imm, u_imm, j_imm, imm_sel;
    logic [`REG_IDX_W-1:0]  rd_m;
    logic [`EXC_W-1:0]      exc;
    alu_op_e                alu_fn;
    branch_op_e             br_fn;
    decode_info_t           nxt;

    assign op      = opcode_e'(inst[6:2]);
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign low_ok  = inst[1:0] == 2'b11;  // 16-bit encodings are not supported
    assign f7_zero = funct7 == 7'h00;
    assign f7_alt  = funct7 == 7'h20;
    // 0x20 only for sub and the arithmetic shifts
    assign f7_ok   = f7_zero ||
                     (f7_alt && (funct3 == 3'b101 || (op == opc_op_reg && funct3 == 3'b000)));

    assign is_lui    = low_ok && op == opc_lui;
    assign is_auipc  = low_ok && op == opc_auipc;
    assign is_jal    = low_ok && op == opc_jal;
    assign is_jalr   = low_ok && op == opc_jalr && funct3 == 3'b000;
    assign is_branch = low_ok && op == opc_branch && br_fn != br_none;
    assign is_op_imm = low_ok && op == opc_op_imm && (funct3[1:0] != 2'b01 || f7_ok);
    assign is_op_reg = low_ok && op == opc_op_reg && f7_ok;
    assign sys_zero  = low_ok && op == opc_system && f7_zero && inst[19:7] == 13'h0;
    assign is_ecall  = sys_zero && inst[24:20] == 5'd0;
    assign is_ebreak = sys_zero && inst[24:20] == 5'd1;

    // loads, stores, fence and csr ops all fall out as illegal
    assign legal = is_lui || is_auipc || is_jal || is_jalr || is_branch ||
                   is_op_imm || is_op_reg || is_ecall || is_ebreak;

    always_comb begin
        case (funct3)
            3'b000:  alu_fn = (op == opc_op_reg && f7_alt) ? alu_sub : alu_add;
            3'b001:  alu_fn = alu_sll;
            3'b010:  alu_fn = alu_slt;
            3'b011:  alu_fn = alu_sltu;
            3'b100:  alu_fn = alu_xor;
            3'b101:  alu_fn = f7_alt ? alu_sra : alu_srl;
            3'b110:  alu_fn = alu_or;
            default: alu_fn = alu_and;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  br_fn = br_beq;
            3'b001:  br_fn = br_bne;
            3'b100:  br_fn = br_blt;
            3'b101:  br_fn = br_bge;
            3'b110:  br_fn = br_bltu;
            3'b111:  br_fn = br_bgeu;
            default: br_fn = br_none;
        endcase
    end

    assign i_imm = {{20{inst[31]}}, inst[31:20]};
    assign b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign u_imm = {inst[31:12], 12'h000};
    assign j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    assign imm_sel = (is_lui || is_auipc) ? u_imm :
                     is_jal               ? j_imm :
                     is_branch            ? b_imm : i_imm;

    // branches and system ops have no destination
    assign rd_m = (is_lui || is_auipc || is_jal || is_jalr || is_op_imm || is_op_reg) ?
                  inst[11:7] : '0;

    assign exc = launch.pc[1:0] != 2'b00 ? `EXC_IAM :
                 !legal                  ? `EXC_II  :
                 is_ecall                ? `EXC_EC  :
                 is_ebreak               ? `EXC_BP  : `EXC_NONE;

    always_comb begin
        nxt.valid     = launch.valid;
        nxt.rs1_val   = launch.rs1_val;
        nxt.rs2_val   = launch.rs2_val;
        nxt.pc        = launch.pc;
        nxt.rd        = rd_m;
        nxt.exccode   = exc;
        nxt.we        = rd_m != '0 && exc == `EXC_NONE;
        nxt.use_imm   = !is_op_reg || exc != `EXC_NONE;
        nxt.imm       = exc == `EXC_NONE ? imm_sel : '0;
        nxt.alu_op    = exc != `EXC_NONE            ? alu_pass_b :
                        is_auipc                    ? alu_add_pc :
                        (is_op_imm || is_op_reg)    ? alu_fn     : alu_pass_b;
        nxt.branch_op = exc != `EXC_NONE ? br_none :
                        is_jal           ? br_jal  :
                        is_jalr          ? br_jalr :
                        is_branch        ? br_fn   : br_none;
    end

    always_ff @(posedge clk) begin
        if (reset)
            dec.valid <= 1'b0;
        else
            dec <= nxt;
    end

    // a clean decode hits one class only
    a_one_class: assert property (@(posedge clk) disable iff (reset)
        launch.valid |-> nxt.exccode != `EXC_NONE ||
            $onehot({is_lui, is_auipc, is_jal, is_jalr, is_branch,
                     is_op_imm, is_op_reg, is_ecall, is_ebreak}));

endmodule

//--- hdl/rv_execute.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_execute import rv_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  decode_info_t  dec,
    output exec_result_t  res
);

    logic [`XLEN-1:0]  op_b;
    logic [4:0]        shamt;
    logic [`XLEN-1:0]  alu_y;
    logic [`XLEN-1:0]  pc_plus4;
    logic [`XLEN-1:0]  jalr_sum;
    logic              taken;
    logic              has_exc;
    logic              is_link;
    exec_result_t      nxt;

    assign op_b  = dec.use_imm ? dec.imm : dec.rs2_val;
    assign shamt = op_b[4:0];

    always_comb begin
        case (dec.alu_op)
            alu_add:    alu_y = dec.rs1_val + op_b;
            alu_sub:    alu_y = dec.rs1_val - op_b;
            alu_sll:    alu_y = dec.rs1_val << shamt;
            alu_slt:    alu_y = {31'd0, $signed(dec.rs1_val) < $signed(op_b)};
            alu_sltu:   alu_y = {31'd0, dec.rs1_val < op_b};
            alu_xor:    alu_y = dec.rs1_val ^ op_b;
            alu_srl:    alu_y = dec.rs1_val >> shamt;
            alu_sra:    alu_y = $signed(dec.rs1_val) >>> shamt;
            alu_or:     alu_y = dec.rs1_val | op_b;
            alu_and:    alu_y = dec.rs1_val & op_b;
            alu_add_pc: alu_y = dec.pc + op_b;
            default:    alu_y = op_b;  // pass_b
        endcase
    end

    always_comb begin
        case (dec.branch_op)
            br_beq:           taken = dec.rs1_val == dec.rs2_val;
            br_bne:           taken = dec.rs1_val != dec.rs2_val;
            br_blt:           taken = $signed(dec.rs1_val) < $signed(dec.rs2_val);
            br_bge:           taken = $signed(dec.rs1_val) >= $signed(dec.rs2_val);
            br_bltu:          taken = dec.rs1_val < dec.rs2_val;
            br_bgeu:          taken = dec.rs1_val >= dec.rs2_val;
            br_jal, br_jalr:  taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    assign has_exc  = dec.exccode != `EXC_NONE;
    assign is_link  = dec.branch_op == br_jal || dec.branch_op == br_jalr;
    assign pc_plus4 = dec.pc + 'd4;
    assign jalr_sum = dec.rs1_val + dec.imm;

    always_comb begin
        nxt.valid    = dec.valid;
        nxt.rd       = dec.rd;
        nxt.we       = dec.we;
        nxt.taken    = taken;
        nxt.exccode  = dec.exccode;
        // trapping instruction stays at its own pc
        nxt.next_pc  = has_exc                   ? dec.pc :
                       dec.branch_op == br_jalr  ? {jalr_sum[`XLEN-1:1], 1'b0} :
                       taken                     ? dec.pc + dec.imm : pc_plus4;
        nxt.rd_value = has_exc ? '0 : is_link ? pc_plus4 : alu_y;
    end

    always_ff @(posedge clk) begin
        if (reset)
            res.valid <= 1'b0;
        else
            res <= nxt;
    end

endmodule

//--- hdl/rv_result.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_result import rv_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  exec_result_t  res,
    output exec_result_t  result,
    output logic [7:0]    done_count
);

    always_ff @(posedge clk) begin
        if (reset) begin
            result         <= '0;
            result.exccode <= `EXC_NONE;
            done_count     <= 8'd0;
        end else if (res.valid) begin
            result     <= res;
            done_count <= done_count + 8'd1;  // wraps at 256
        end
    end

    a_count_on_valid: assert property (@(posedge clk) disable iff (reset)
        done_count != $past(done_count) |-> $past(res.valid));

endmodule

//--- hdl/rv_exec_top.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_exec_top import rv_pkg::*; (
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`AXI_ADDR_W-1:0]  s_awaddr,
    input  logic                    s_awvalid,
    output logic                    s_awready,
    input  logic [`XLEN-1:0]        s_wdata,
    input  logic [`XLEN/8-1:0]      s_wstrb,
    input  logic                    s_wvalid,
    output logic                    s_wready,
    output logic [1:0]              s_bresp,
    output logic                    s_bvalid,
    input  logic                    s_bready,
    input  logic [`AXI_ADDR_W-1:0]  s_araddr,
    input  logic                    s_arvalid,
    output logic                    s_arready,
    output logic [`XLEN-1:0]        s_rdata,
    output logic [1:0]              s_rresp,
    output logic                    s_rvalid,
    input  logic                    s_rready
);

    decode_info_t      launch;
    decode_info_t      dec;
    exec_result_t      res;
    exec_result_t      result;
    logic [`XLEN-1:0]  inst;
    logic [7:0]        done_count;

    rv_axil_regs u_regs (
        .clk        (clk),
        .reset      (reset),
        .s_awaddr   (s_awaddr),
        .s_awvalid  (s_awvalid),
        .s_awready  (s_awready),
        .s_wdata    (s_wdata),
        .s_wstrb    (s_wstrb),
        .s_wvalid   (s_wvalid),
        .s_wready   (s_wready),
        .s_bresp    (s_bresp),
        .s_bvalid   (s_bvalid),
        .s_bready   (s_bready),
        .s_araddr   (s_araddr),
        .s_arvalid  (s_arvalid),
        .s_arready  (s_arready),
        .s_rdata    (s_rdata),
        .s_rresp    (s_rresp),
        .s_rvalid   (s_rvalid),
        .s_rready   (s_rready),
        .launch     (launch),
        .inst       (inst),
        .result     (result),
        .done_count (done_count)
    );

    rv_decode u_decode (
        .clk    (clk),
        .reset  (reset),
        .inst   (inst),
        .launch (launch),
        .dec    (dec)
    );

    rv_execute u_execute (
        .clk   (clk),
        .reset (reset),
        .dec   (dec),
        .res   (res)
    );

    rv_result u_result (
        .clk        (clk),
        .reset      (reset),
        .res        (res),
        .result     (result),
        .done_count (done_count)
    );

endmodule

//--- verif/rv_clock_gen.sv
`timescale 1ns/1ps

module rv_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

//--- verif/rv_exec_tb.sv
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_exec_tb;

    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] pc;
        logic [31:0] exp_rd_value;
        logic [31:0] exp_next_pc;
        logic [3:0]  exp_exc;
        logic        exp_we;
        logic [4:0]  exp_rd;
    } row_t;

    logic        clk;
    logic        reset;
    logic [4:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [4:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    row_t        rows[$];
    int          errors;
    int          checks;
    int          cycles;
    int          limit;
    int          row_err;

    rv_clock_gen u_clk (
        .clk   (clk),
        .reset (reset)
    );

    rv_exec_top uut (
        .clk       (clk),
        .reset     (reset),
        .s_awaddr  (awaddr),
        .s_awvalid (awvalid),
        .s_awready (awready),
        .s_wdata   (wdata),
        .s_wstrb   (wstrb),
        .s_wvalid  (wvalid),
        .s_wready  (wready),
        .s_bresp   (bresp),
        .s_bvalid  (bvalid),
        .s_bready  (bready),
        .s_araddr  (araddr),
        .s_arvalid (arvalid),
        .s_arready (arready),
        .s_rdata   (rdata),
        .s_rresp   (rresp),
        .s_rvalid  (rvalid),
        .s_rready  (rready)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout: run took more than %0d cycles", limit);
            $display("Errors found");
            $finish;
        end
    end

    task automatic add_row(input logic [31:0] inst, input logic [31:0] rs1,
                           input logic [31:0] rs2, input logic [31:0] pc,
                           input logic [31:0] rd_value, input logic [31:0] next_pc,
                           input logic [3:0] exc, input logic we, input logic [4:0] rd);
        row_t r;
        r = {inst, rs1, rs2, pc, rd_value, next_pc, exc, we, rd};
        rows.push_back(r);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act, inout int row_err);
        checks++;
        if (exp !== act) begin
            $display("mismatch at %0t ns: %s expected %h got %h", $time, name, exp, act);
            errors++;
            row_err++;
        end
    endtask

    task automatic axi_write(input logic [4:0] addr, input logic [31:0] data);
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= 4'hf;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        do @(negedge clk); while (!(awready && wready));
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(negedge clk); while (!bvalid);
        check_value("bresp", 32'd0, {30'd0, bresp}, row_err);
        @(posedge clk);
    endtask

    task automatic axi_read(input logic [4:0] addr, output logic [31:0] data);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b1;
        do @(negedge clk); while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        do @(negedge clk); while (!rvalid);
        data = rdata;
        check_value("rresp", 32'd0, {30'd0, rresp}, row_err);
        @(posedge clk);
    endtask

    // first write held in its response, second one offered meanwhile
    task automatic write_stalled(input logic [31:0] d0, input logic [31:0] d1);
        @(posedge clk);
        awaddr  <= `ADDR_INST;
        wdata   <= d0;
        wstrb   <= 4'hf;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        bready  <= 1'b0;
        do @(negedge clk); while (!(awready && wready));
        @(posedge clk);
        wdata <= d1;  // valids stay high
        repeat (5) begin
            @(negedge clk);
            if (awready || wready) begin
                $display("write accepted at %0t ns while a response was pending", $time);
                errors++;
                row_err++;
            end
            if (!bvalid) begin
                $display("write response dropped at %0t ns without bready", $time);
                errors++;
                row_err++;
            end
        end
        @(posedge clk);
        bready <= 1'b1;
        do @(negedge clk); while (!(awready && wready));
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(negedge clk); while (!bvalid);
        check_value("bresp", 32'd0, {30'd0, bresp}, row_err);
        @(posedge clk);
    endtask

    task automatic wait_done(input logic [7:0] target);
        logic [31:0] st;
        axi_read(`ADDR_STATUS, st);
        while (st[23:16] != target)
            axi_read(`ADDR_STATUS, st);
    endtask

    task automatic build_table;
        // R-type and I-type ALU, pc 0x100
        add_row(32'h002082B3, 32'd5, 32'd7, 32'h100, 32'd12, 32'h104, 4'd15, 1'b1, 5'd5);
        add_row(32'h402082B3, 32'd5, 32'd7, 32'h100, 32'hFFFFFFFE, 32'h104, 4'd15, 1'b1, 5'd5);
        add_row(32'h002092B3, 32'd1, 32'h24, 32'h100, 32'h10, 32'h104, 4'd15, 1'b1, 5'd5);
        add_row(32'h0020A2B3, 32'hFFFFFFFF, 32'd1, 32'h100, 32'd1, 32'h104, 4'd15, 1'b1, 5'd5);
        add_row(32'h0020B2B3, 32'hFFFFFFFF, 32'd1, 32'h100, 32'd0, 32'h104, 4'd15, 1'b1, 5'd5);
        add_row(32'h0020C2B3, 32'hF0F0F0F0, 32'hFF00FF00, 32'h100, 32'h0FF00FF0, 32'h104,
                4'd15, 1'b1, 5'd5);
        add_row(32'h0020D2B3, 32'h80000000, 32'd4, 32'h100, 32'h08000000, 32'h104,
                4'd15, 1'b1, 5'd5);
        add_row(32'h4020D2B3, 32'h80000000, 32'd4, 32'h100, 32'hF8000000, 32'h104,
                4'd15, 1'b1, 5'd5);
        add_row(32'h0020E2B3, 32'h00F0, 32'h0F00, 32'h100, 32'h0FF0, 32'h104, 4'd15, 1'b1, 5'd5);
        add_row(32'h0020F2B3, 32'hFF0F, 32'h0FFF, 32'h100, 32'h0F0F, 32'h104, 4'd15, 1'b1, 5'd5);
        add_row(32'hFFB08293, 32'd3, 32'd0, 32'h100, 32'hFFFFFFFE, 32'h104, 4'd15, 1'b1, 5'd5);
        add_row(32'h00309293, 32'h11, 32'd0, 32'h100, 32'h88, 32'h104, 4'd15, 1'b1, 5'd5);
        add_row(32'hFFF0A293, 32'hFFFFFFFE, 32'd0, 32'h100, 32'd1, 32'h104, 4'd15, 1'b1, 5'd5);
        add_row(32'hFFF0B293, 32'd5, 32'd0, 32'h100, 32'd1, 32'h104, 4'd15, 1'b1, 5'd5);
        add_row(32'h0F00C293, 32'hFF, 32'd0, 32'h100, 32'h0F, 32'h104, 4'd15, 1'b1, 5'd5);
        add_row(32'h0040D293, 32'h80000000, 32'd0, 32'h100, 32'h08000000, 32'h104,
                4'd15, 1'b1, 5'd5);
        add_row(32'h4040D293, 32'h80000000, 32'd0, 32'h100, 32'hF8000000, 32'h104,
                4'd15, 1'b1, 5'd5);
        add_row(32'h1230E293, 32'h1000, 32'd0, 32'h100, 32'h1123, 32'h104, 4'd15, 1'b1, 5'd5);
        add_row(32'h0FF0F293, 32'h1234, 32'd0, 32'h100, 32'h34, 32'h104, 4'd15, 1'b1, 5'd5);
        // lui, auipc
        add_row(32'h123452B7, 32'd0, 32'd0, 32'h100, 32'h12345000, 32'h104, 4'd15, 1'b1, 5'd5);
        add_row(32'h00001297, 32'd0, 32'd0, 32'h100, 32'h1100, 32'h104, 4'd15, 1'b1, 5'd5);
        // branches, offset 8, taken then not taken
        add_row(32'h00208463, 32'd9, 32'd9, 32'h100, 32'd8, 32'h108, 4'd15, 1'b0, 5'd0);
        add_row(32'h00208463, 32'd9, 32'd8, 32'h100, 32'd8, 32'h104, 4'd15, 1'b0, 5'd0);
        add_row(32'h00209463, 32'd1, 32'd2, 32'h100, 32'd8, 32'h108, 4'd15, 1'b0, 5'd0);
        add_row(32'h00209463, 32'd3, 32'd3, 32'h100, 32'd8, 32'h104, 4'd15, 1'b0, 5'd0);
        add_row(32'h0020C463, 32'hFFFFFFFF, 32'd1, 32'h100, 32'd8, 32'h108, 4'd15, 1'b0, 5'd0);
        add_row(32'h0020C463, 32'd1, 32'hFFFFFFFF, 32'h100, 32'd8, 32'h104, 4'd15, 1'b0, 5'd0);
        add_row(32'h0020D463, 32'd1, 32'hFFFFFFFF, 32'h100, 32'd8, 32'h108, 4'd15, 1'b0, 5'd0);
        add_row(32'h0020D463, 32'hFFFFFFFF, 32'd1, 32'h100, 32'd8, 32'h104, 4'd15, 1'b0, 5'd0);
        add_row(32'h0020E463, 32'd1, 32'hFFFFFFFF, 32'h100, 32'd8, 32'h108, 4'd15, 1'b0, 5'd0);
        add_row(32'h0020E463, 32'hFFFFFFFF, 32'd1, 32'h100, 32'd8, 32'h104, 4'd15, 1'b0, 5'd0);
        add_row(32'h0020F463, 32'hFFFFFFFF, 32'd1, 32'h100, 32'd8, 32'h108, 4'd15, 1'b0, 5'd0);
        add_row(32'h0020F463, 32'd1, 32'hFFFFFFFF, 32'h100, 32'd8, 32'h104, 4'd15, 1'b0, 5'd0);
        // jal +16, jalr 3(x1) with bit 0 cleared
        add_row(32'h010000EF, 32'd0, 32'd0, 32'h100, 32'h104, 32'h110, 4'd15, 1'b1, 5'd1);
        add_row(32'h003080E7, 32'h200, 32'd0, 32'h100, 32'h104, 32'h202, 4'd15, 1'b1, 5'd1);
        add_row(32'h00208033, 32'd5, 32'd7, 32'h100, 32'd12, 32'h104, 4'd15, 1'b0, 5'd0);
        // load, store, csrrw, low bits 00, ecall, ebreak, misaligned pc
        add_row(32'h0000A283, 32'd1, 32'd2, 32'h100, 32'd0, 32'h100, 4'd2, 1'b0, 5'd0);
        add_row(32'h0020A023, 32'd1, 32'd2, 32'h100, 32'd0, 32'h100, 4'd2, 1'b0, 5'd0);
        add_row(32'h300092F3, 32'd1, 32'd2, 32'h100, 32'd0, 32'h100, 4'd2, 1'b0, 5'd0);
        add_row(32'h002082B0, 32'd1, 32'd2, 32'h100, 32'd0, 32'h100, 4'd2, 1'b0, 5'd0);
        add_row(32'h00000073, 32'd0, 32'd0, 32'h100, 32'd0, 32'h100, 4'd11, 1'b0, 5'd0);
        add_row(32'h00100073, 32'd0, 32'd0, 32'h100, 32'd0, 32'h100, 4'd3, 1'b0, 5'd0);
        add_row(32'h0000A283, 32'd1, 32'd2, 32'h102, 32'd0, 32'h102, 4'd0, 1'b0, 5'd0);
        add_row(32'h002082B3, 32'd5, 32'd7, 32'h106, 32'd0, 32'h106, 4'd0, 1'b0, 5'd5);
    endtask

    initial begin
        logic [31:0] st;
        logic [31:0] rd_val;
        logic [31:0] npc;
        logic [7:0]  count;

        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        errors  = 0;
        checks  = 0;
        row_err = 0;
        limit   = 0;

        build_table();
        limit = rows.size() * 40 + 200;

        @(negedge reset);
        @(posedge clk);
        axi_read(`ADDR_STATUS, st);
        count = st[23:16];

        foreach (rows[i]) begin
            row_err = 0;
            axi_write(`ADDR_RS1, rows[i].rs1);
            axi_write(`ADDR_RS2, rows[i].rs2);
            axi_write(`ADDR_PC, rows[i].pc);
            axi_write(`ADDR_INST, rows[i].inst);
            count = count + 8'd1;
            wait_done(count);
            axi_read(`ADDR_RD_VALUE, rd_val);
            axi_read(`ADDR_NEXT_PC, npc);
            axi_read(`ADDR_STATUS, st);
            check_value("rd_value", rows[i].exp_rd_value, rd_val, row_err);
            check_value("next_pc", rows[i].exp_next_pc, npc, row_err);
            check_value("exccode", {28'd0, rows[i].exp_exc}, {28'd0, st[3:0]}, row_err);
            check_value("we", {31'd0, rows[i].exp_we}, {31'd0, st[4]}, row_err);
            check_value("rd", {27'd0, rows[i].exp_rd}, {27'd0, st[12:8]}, row_err);
            $display("row %0d inst %h: %s", i, rows[i].inst, row_err == 0 ? "ok" : "FAILED");
        end

        // three launches back to back, the first one held by bready
        row_err = 0;
        axi_write(`ADDR_RS1, 32'd10);
        axi_write(`ADDR_RS2, 32'd3);
        axi_write(`ADDR_PC, 32'h200);
        write_stalled(32'h002082B3, 32'h402082B3);
        axi_write(`ADDR_INST, 32'h0020F2B3);
        count = count + 8'd3;
        wait_done(count);
        repeat (4) @(posedge clk);
        axi_read(`ADDR_STATUS, st);
        axi_read(`ADDR_RD_VALUE, rd_val);
        check_value("done_count", {24'd0, count}, {24'd0, st[23:16]}, row_err);
        check_value("rd_value", 32'd2, rd_val, row_err);
        $display("back to back: %s", row_err == 0 ? "ok" : "FAILED");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_axil_regs.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_result.sv
hdl/rv_exec_top.sv
verif/rv_clock_gen.sv
verif/rv_exec_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module rv_exec_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vrv_exec_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "No errors"; then
    exit 0
fi
exit 1
